//--- rv_pkg.sv
package rv_pkg;

	// machine word, also the width of every gpr and csr
	typedef logic [63:0] xlen_t;
	// raw 32-bit instruction
	typedef logic [31:0] inst_t;
	// rd / rs index
	typedef logic [4:0] reg_idx_t;
	// csr number from imm field
	typedef logic [11:0] csr_addr_t;
	// funct3 field of an instruction
	typedef logic [2:0] funct3_t;
	// byte position inside a doubleword
	typedef logic [2:0] byte_off_t;

	// machine csr numbers
	localparam csr_addr_t CSR_MSTATUS = 12'h300;
	localparam csr_addr_t CSR_MTVEC   = 12'h305;
	localparam csr_addr_t CSR_MEPC    = 12'h341;
	localparam csr_addr_t CSR_MCAUSE  = 12'h342;

	// mstatus after reset, mpp = machine and uxl/sxl = 64 bit
	localparam xlen_t MSTATUS_RESET = 64'h0000_000a_0000_1800;

	// environment call from m-mode
	localparam xlen_t CAUSE_ECALL_M = 64'd11;

	// x0..x31
	localparam int NUM_GPR = 32;

endpackage

//--- wb_pkg.sv
package wb_pkg;

	// what the writeback stage does with an item
	typedef logic [2:0] wb_kind_t;

	// bubble or invalid slot
	localparam wb_kind_t WB_NONE  = 3'd0;
	localparam wb_kind_t WB_ALU   = 3'd1;
	// *w ops, low word sign extended
	localparam wb_kind_t WB_ALU_W = 3'd2;
	localparam wb_kind_t WB_LOAD  = 3'd3;
	// jal / jalr, rd gets pc+4
	localparam wb_kind_t WB_LINK  = 3'd4;
	localparam wb_kind_t WB_CSRRW = 3'd5;
	localparam wb_kind_t WB_ECALL = 3'd6;
	localparam wb_kind_t WB_MRET  = 3'd7;

	// load funct3 encodings
	localparam rv_pkg::funct3_t F3_LB  = 3'b000;
	localparam rv_pkg::funct3_t F3_LH  = 3'b001;
	localparam rv_pkg::funct3_t F3_LW  = 3'b010;
	localparam rv_pkg::funct3_t F3_LD  = 3'b011;
	localparam rv_pkg::funct3_t F3_LBU = 3'b100;
	localparam rv_pkg::funct3_t F3_LHU = 3'b101;
	localparam rv_pkg::funct3_t F3_LWU = 3'b110;

endpackage

//--- wb_stage_reg.sv
`timescale 1ns/1ps

module wb_stage_reg (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  rv_pkg::xlen_t      in_pc,
	input  rv_pkg::inst_t      in_inst,
	input  wb_pkg::wb_kind_t   in_kind,
	input  rv_pkg::xlen_t      alu_result,
	input  rv_pkg::xlen_t      mem_rdata,
	input  rv_pkg::xlen_t      src1,
	output logic               s_valid,
	output rv_pkg::xlen_t      s_pc,
	output rv_pkg::inst_t      s_inst,
	output wb_pkg::wb_kind_t   s_kind,
	output rv_pkg::xlen_t      s_alu,
	output rv_pkg::xlen_t      s_mem,
	output rv_pkg::xlen_t      s_src1
);

	// control part of the stage
	// an empty slot turns into WB_NONE here so later logic only looks at kind
	always_ff @(posedge clk) begin
		if (rst) begin
			s_valid <= 1'b0;
			s_kind  <= wb_pkg::WB_NONE;
		end else begin
			s_valid <= in_valid;
			s_kind  <= in_valid ? in_kind : wb_pkg::WB_NONE;
		end
	end

	// payload, captured every cycle
	always_ff @(posedge clk) begin
		s_pc   <= in_pc;
		s_inst <= in_inst;
		s_alu  <= alu_result;
		// raw doubleword, lanes picked later
		s_mem  <= mem_rdata;
		s_src1 <= src1;
	end

endmodule

//--- load_align.sv
`timescale 1ns/1ps

module load_align (
	input  rv_pkg::inst_t s_inst,
	input  rv_pkg::xlen_t s_alu,
	input  rv_pkg::xlen_t s_mem,
	output rv_pkg::xlen_t load_value
);

	rv_pkg::byte_off_t off;
	rv_pkg::funct3_t   f3;
	rv_pkg::xlen_t     shifted;

	// low address bits select the lane
	assign off = s_alu[2:0];
	assign f3  = s_inst[14:12];

	// bring the addressed lanes down to bit 0
	// natural alignment keeps the field inside the doubleword
	assign shifted = s_mem >> {off, 3'b000};

	always_comb begin
		case (f3)
			// signed byte
			wb_pkg::F3_LB: begin
				load_value = {{56{shifted[7]}}, shifted[7:0]};
			end
			// signed half
			wb_pkg::F3_LH: begin
				load_value = {{48{shifted[15]}}, shifted[15:0]};
			end
			// signed word
			wb_pkg::F3_LW: begin
				load_value = {{32{shifted[31]}}, shifted[31:0]};
			end
			// full doubleword, offset is 0
			wb_pkg::F3_LD: begin
				load_value = shifted;
			end
			// unsigned variants
			wb_pkg::F3_LBU: begin
				load_value = {56'd0, shifted[7:0]};
			end
			wb_pkg::F3_LHU: begin
				load_value = {48'd0, shifted[15:0]};
			end
			wb_pkg::F3_LWU: begin
				load_value = {32'd0, shifted[31:0]};
			end
			default: begin
				load_value = '0;
			end
		endcase
	end

endmodule

//--- wb_select.sv
`timescale 1ns/1ps

module wb_select (
	input  wb_pkg::wb_kind_t s_kind,
	input  rv_pkg::xlen_t    s_pc,
	input  rv_pkg::inst_t    s_inst,
	input  rv_pkg::xlen_t    s_alu,
	input  rv_pkg::xlen_t    load_value,
	input  rv_pkg::xlen_t    csr_rdata,
	output logic             gpr_we,
	output rv_pkg::reg_idx_t gpr_waddr,
	output rv_pkg::xlen_t    gpr_wdata
);

	// rd field
	assign gpr_waddr = s_inst[11:7];

	always_comb begin
		gpr_we    = 1'b1;
		gpr_wdata = s_alu;
		case (s_kind)
			wb_pkg::WB_ALU: begin
				gpr_wdata = s_alu;
			end
			// addw/subw/... keep only the low word
			wb_pkg::WB_ALU_W: begin
				gpr_wdata = {{32{s_alu[31]}}, s_alu[31:0]};
			end
			wb_pkg::WB_LOAD: begin
				gpr_wdata = load_value;
			end
			// return address
			wb_pkg::WB_LINK: begin
				gpr_wdata = s_pc + 64'd4;
			end
			// old csr value goes to rd
			wb_pkg::WB_CSRRW: begin
				gpr_wdata = csr_rdata;
			end
			// none, ecall, mret write no gpr
			default: begin
				gpr_we    = 1'b0;
				gpr_wdata = '0;
			end
		endcase
	end

endmodule

//--- gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
	input  logic             clk,
	input  logic             gpr_we,
	input  rv_pkg::reg_idx_t gpr_waddr,
	input  rv_pkg::xlen_t    gpr_wdata,
	input  rv_pkg::reg_idx_t gpr_raddr,
	output rv_pkg::xlen_t    gpr_rdata
);

	// x0 slot exists but is never written
	rv_pkg::xlen_t regs [rv_pkg::NUM_GPR];

	// single write port
	always_ff @(posedge clk) begin
		if (gpr_we && gpr_waddr != 5'd0) begin
			regs[gpr_waddr] <= gpr_wdata;
		end
	end

	// async read, x0 hardwired to zero
	always_comb begin
		if (gpr_raddr == 5'd0) begin
			gpr_rdata = '0;
		end else begin
			gpr_rdata = regs[gpr_raddr];
		end
	end

endmodule

//--- csr_file.sv
`timescale 1ns/1ps

module csr_file (
	input  logic             clk,
	input  logic             rst,
	input  wb_pkg::wb_kind_t s_kind,
	input  rv_pkg::xlen_t    s_pc,
	input  rv_pkg::inst_t    s_inst,
	input  rv_pkg::xlen_t    s_src1,
	output rv_pkg::xlen_t    csr_rdata,
	output logic             redirect_valid,
	output rv_pkg::xlen_t    redirect_pc
);

	rv_pkg::csr_addr_t csr_addr;
	rv_pkg::xlen_t     mtvec;
	rv_pkg::xlen_t     mepc;
	rv_pkg::xlen_t     mcause;
	rv_pkg::xlen_t     mstatus;

	// csr number sits in the I-type immediate
	assign csr_addr = s_inst[31:20];

	// old value, read before this item's write lands
	always_comb begin
		case (csr_addr)
			rv_pkg::CSR_MSTATUS: csr_rdata = mstatus;
			rv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
			rv_pkg::CSR_MEPC:    csr_rdata = mepc;
			rv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
			// unimplemented csr reads zero
			default:             csr_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
			mstatus <= rv_pkg::MSTATUS_RESET;
		end else begin
			case (s_kind)
				// csrrw swaps in src1
				wb_pkg::WB_CSRRW: begin
					case (csr_addr)
						rv_pkg::CSR_MSTATUS: mstatus <= s_src1;
						rv_pkg::CSR_MTVEC:   mtvec   <= s_src1;
						rv_pkg::CSR_MEPC:    mepc    <= s_src1;
						rv_pkg::CSR_MCAUSE:  mcause  <= s_src1;
						// unknown address is dropped
						default: begin
						end
					endcase
				end
				// trap entry, save pc and cause
				wb_pkg::WB_ECALL: begin
					mepc   <= s_pc;
					mcause <= rv_pkg::CAUSE_ECALL_M;
				end
				default: begin
				end
			endcase
		end
	end

	// trap goes to mtvec, mret returns to mepc
	// both straight from the stage register, same cycle
	assign redirect_valid = (s_kind == wb_pkg::WB_ECALL) || (s_kind == wb_pkg::WB_MRET);

	always_comb begin
		case (s_kind)
			wb_pkg::WB_ECALL: redirect_pc = mtvec;
			wb_pkg::WB_MRET:  redirect_pc = mepc;
			default:          redirect_pc = '0;
		endcase
	end

endmodule

//--- wbu_top.sv
`timescale 1ns/1ps

module wbu_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  rv_pkg::xlen_t    in_pc,
	input  rv_pkg::inst_t    in_inst,
	input  wb_pkg::wb_kind_t in_kind,
	input  rv_pkg::xlen_t    alu_result,
	input  rv_pkg::xlen_t    mem_rdata,
	input  rv_pkg::xlen_t    src1,
	input  rv_pkg::reg_idx_t gpr_raddr,
	output rv_pkg::xlen_t    gpr_rdata,
	output logic             redirect_valid,
	output rv_pkg::xlen_t    redirect_pc
);

	// stage register outputs
	rv_pkg::xlen_t    s_pc;
	rv_pkg::inst_t    s_inst;
	wb_pkg::wb_kind_t s_kind;
	rv_pkg::xlen_t    s_alu;
	rv_pkg::xlen_t    s_mem;
	rv_pkg::xlen_t    s_src1;

	// writeback datapath
	rv_pkg::xlen_t    load_value;
	rv_pkg::xlen_t    csr_rdata;
	logic             gpr_we;
	rv_pkg::reg_idx_t gpr_waddr;
	rv_pkg::xlen_t    gpr_wdata;

	// occupancy bit left open, kind already carries it
	wb_stage_reg i_stage_reg (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_pc      (in_pc),
		.in_inst    (in_inst),
		.in_kind    (in_kind),
		.alu_result (alu_result),
		.mem_rdata  (mem_rdata),
		.src1       (src1),
		.s_valid    (),
		.s_pc       (s_pc),
		.s_inst     (s_inst),
		.s_kind     (s_kind),
		.s_alu      (s_alu),
		.s_mem      (s_mem),
		.s_src1     (s_src1)
	);

	load_align i_load_align (
		.s_inst     (s_inst),
		.s_alu      (s_alu),
		.s_mem      (s_mem),
		.load_value (load_value)
	);

	wb_select i_wb_select (
		.s_kind     (s_kind),
		.s_pc       (s_pc),
		.s_inst     (s_inst),
		.s_alu      (s_alu),
		.load_value (load_value),
		.csr_rdata  (csr_rdata),
		.gpr_we     (gpr_we),
		.gpr_waddr  (gpr_waddr),
		.gpr_wdata  (gpr_wdata)
	);

	gpr_file i_gpr_file (
		.clk        (clk),
		.gpr_we     (gpr_we),
		.gpr_waddr  (gpr_waddr),
		.gpr_wdata  (gpr_wdata),
		.gpr_raddr  (gpr_raddr),
		.gpr_rdata  (gpr_rdata)
	);

	csr_file i_csr_file (
		.clk            (clk),
		.rst            (rst),
		.s_kind         (s_kind),
		.s_pc           (s_pc),
		.s_inst         (s_inst),
		.s_src1         (s_src1),
		.csr_rdata      (csr_rdata),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

//--- tb_wbu.sv
`timescale 1ns/1ps

module tb_wbu;

	localparam int NUM_VEC     = 24;
	// one row of wbu_vectors.txt holds this many hex fields
	localparam int NUM_FIELDS  = 10;
	localparam int RST_CYCLES  = 16;
	// an item needs at most 4 cycles, 8 per item leaves margin
	localparam int WATCHDOG_NS = (RST_CYCLES + NUM_VEC * 8) * 100;

	logic             clk;
	logic             rst;
	logic             in_valid;
	rv_pkg::xlen_t    in_pc;
	rv_pkg::inst_t    in_inst;
	wb_pkg::wb_kind_t in_kind;
	rv_pkg::xlen_t    alu_result;
	rv_pkg::xlen_t    mem_rdata;
	rv_pkg::xlen_t    src1;
	rv_pkg::reg_idx_t gpr_raddr;
	rv_pkg::xlen_t    gpr_rdata;
	logic             redirect_valid;
	rv_pkg::xlen_t    redirect_pc;

	// flat copy of the vector file, field f of row r at r*NUM_FIELDS+f
	rv_pkg::xlen_t vec_mem [NUM_VEC * NUM_FIELDS];
	int err_count;
	int test_count;

	wbu_top i_wbu_top (
		.clk            (clk),
		.rst            (rst),
		.in_valid       (in_valid),
		.in_pc          (in_pc),
		.in_inst        (in_inst),
		.in_kind        (in_kind),
		.alu_result     (alu_result),
		.mem_rdata      (mem_rdata),
		.src1           (src1),
		.gpr_raddr      (gpr_raddr),
		.gpr_rdata      (gpr_rdata),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// pc only matters while a redirect is expected
	task automatic check_redirect(input bit exp_valid, input rv_pkg::xlen_t exp_pc);
		if (redirect_valid !== exp_valid) begin
			err_count++;
			$display("Error at %0t: redirect_valid is %b, expected %b",
				$time, redirect_valid, exp_valid);
		end else if (exp_valid && redirect_pc !== exp_pc) begin
			err_count++;
			$display("Error at %0t: redirect_pc is %h, expected %h",
				$time, redirect_pc, exp_pc);
		end
	endtask

	task automatic check_xlen(input rv_pkg::xlen_t exp_value);
		if (gpr_rdata !== exp_value) begin
			err_count++;
			$display("Error at %0t: x%0d reads %h, expected %h",
				$time, gpr_raddr, gpr_rdata, exp_value);
		end
	endtask

	// read port was pointed at the row's register one cycle earlier
	task automatic check_row_reg(input int row);
		check_xlen(vec_mem[row * NUM_FIELDS + 7]);
	endtask

	task automatic apply_item(input int row);
		int base;
		base       = row * NUM_FIELDS;
		in_valid   = 1'b1;
		in_kind    = vec_mem[base][2:0];
		in_pc      = vec_mem[base + 1];
		in_inst    = vec_mem[base + 2][31:0];
		alu_result = vec_mem[base + 3];
		mem_rdata  = vec_mem[base + 4];
		src1       = vec_mem[base + 5];
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: mismatch", name);
		end
	endtask

	initial begin
		int gaps;
		int pend;
		int start_err;
		clk        = 1'b0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_pc      = '0;
		in_inst    = '0;
		in_kind    = wb_pkg::WB_NONE;
		alu_result = '0;
		mem_rdata  = '0;
		src1       = '0;
		gpr_raddr  = '0;
		err_count  = 0;
		test_count = 0;
		void'($urandom(32'h6fc40128));
		$readmemh("wbu_vectors.txt", vec_mem);

		// no redirect while in reset nor in the first cycle out of it
		start_err = err_count;
		repeat (RST_CYCLES) begin
			@(posedge clk);
			#1;
			check_redirect(1'b0, '0);
		end
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_redirect(1'b0, '0);
		report_test("reset", start_err);

		pend = -1;
		for (int i = 0; i < NUM_VEC; i++) begin
			apply_item(i);
			@(posedge clk);
			#1;
			// write of the previous row landed on this edge
			if (pend >= 0) begin
				check_row_reg(pend);
				report_test($sformatf("vector %0d", pend), start_err);
			end
			// bubbles keep the stale fields, only valid drops
			in_valid  = 1'b0;
			// read port follows the row just captured
			gpr_raddr = vec_mem[i * NUM_FIELDS + 6][4:0];
			start_err = err_count;
			check_redirect(vec_mem[i * NUM_FIELDS + 8][0], vec_mem[i * NUM_FIELDS + 9]);
			pend = i;
			gaps = $urandom % 4;
			repeat (gaps) begin
				@(posedge clk);
				#1;
				if (pend >= 0) begin
					check_row_reg(pend);
					report_test($sformatf("vector %0d", pend), start_err);
					pend = -1;
				end
				check_redirect(1'b0, '0);
			end
		end
		@(posedge clk);
		#1;
		if (pend >= 0) begin
			check_row_reg(pend);
			report_test($sformatf("vector %0d", pend), start_err);
		end

		$display("%0d tests run, %0d errors", test_count, err_count);
		if (err_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// ends a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all vectors were checked");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- wbu_vectors.txt
// kind pc inst alu_result mem_rdata src1 check_reg check_value redirect redirect_pc
// all hex, kind codes as in wb_pkg, redirect_pc only compared when redirect is 1
1 0 000000b3 1122334455667788 0 0 01 1122334455667788 0 0
2 0 0000013b 0000000080000001 0 0 02 ffffffff80000001 0 0
4 1000 000001ef 0 0 0 03 0000000000001004 0 0
3 0 00000203 2003 0123456789abcdef 0 04 ffffffffffffff89 0 0
3 0 00004283 2003 0123456789abcdef 0 05 0000000000000089 0 0
3 0 00001303 2006 0123456789abcdef 0 06 0000000000000123 0 0
3 0 00005383 2002 0123456789abcdef 0 07 00000000000089ab 0 0
3 0 00001403 2002 0123456789abcdef 0 08 ffffffffffff89ab 0 0
3 0 00002483 2004 0123456789abcdef 0 09 0000000001234567 0 0
3 0 00002503 2000 0123456789abcdef 0 0a ffffffff89abcdef 0 0
3 0 00006583 2000 0123456789abcdef 0 0b 0000000089abcdef 0 0
3 0 00003603 2000 0123456789abcdef 0 0c 0123456789abcdef 0 0
3 0 00000683 2007 0123456789abcdef 0 0d 0000000000000001 0 0
1 0 00000033 00000000deadbeef 0 0 00 0000000000000000 0 0
0 0 000000b3 ffffffffffffffff 0 0 01 1122334455667788 0 0
5 0 30001773 0 0 88 0e 0000000a00001800 0 0
5 0 300017f3 0 0 0 0f 0000000000000088 0 0
5 0 30501873 0 0 80000100 10 0000000000000000 0 0
6 20000040 00000073 0 0 0 10 0000000000000000 1 80000100
5 0 341018f3 0 0 3000 11 0000000020000040 0 0
5 0 34201973 0 0 0 12 000000000000000b 0 0
7 0 30200073 0 0 0 12 000000000000000b 1 3000
5 0 7c0019f3 0 0 ffff 13 0000000000000000 0 0
2 0 00000a3b ffffffff7fffffff 0 0 14 000000007fffffff 0 0

//--- wbu_top.f
rv_pkg.sv
wb_pkg.sv
wb_stage_reg.sv
load_align.sv
wb_select.sv
gpr_file.sv
csr_file.sv
wbu_top.sv
tb_wbu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the writeback stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f wbu_top.f --top-module tb_wbu -o tb_wbu
./obj_dir/tb_wbu > sim.log
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
